/* files.f */
verilog/fetch_pkg.sv
verilog/fetch_pc.sv
verilog/thread_select.sv
verilog/fetch_stage.sv
test/clock_gen.sv
test/fetch_stage_tb.sv

/* Bender.yml */
# two-thread fetch front end, RTL and testbench
package:
  name: fetch_stage

sources:
  # package first, the modules import it
  - verilog/fetch_pkg.sv
  - verilog/fetch_pc.sv
  - verilog/thread_select.sv
  - verilog/fetch_stage.sv

  - target: test
    files:
      - test/clock_gen.sv
      - test/fetch_stage_tb.sv

/* test/fetch_stage_tb.sv */
/*
 * testbench for the two-thread fetch front end
 * memory model, random stimulus, shadow pcs and checking assertions
 */
`default_nettype none

module fetch_stage_tb;
	import fetch_pkg::*;

	localparam int    PERIOD       = 20;
	localparam int    RESET_CYCLES = 4;
	localparam int    NUM_CYCLES   = 1000;
	localparam int    TIMEOUT      = (RESET_CYCLES + NUM_CYCLES + 50) * PERIOD;
	localparam addr_t RESET_PC1    = 64'h0000_0000_0000_0100;
	localparam addr_t RESET_PC2    = 64'h0000_0000_0000_8000;

	logic          clock, reset;
	mem_word_t     imem_data;
	logic          imem_valid, fetch_enable, two_threads;
	stall_t        stall;
	redirect_t     redirect;
	addr_t         fetch_addr;
	fetch_packet_t packet;

	int            errors = 0;
	int            packets = 0;
	int            redirects = 0;

	// shadow of the fetch state
	thread_state_t exp_state, exp_next_state;
	addr_t         exp_pc1, exp_pc2, exp_addr;
	logic          exp_rob, redirect_self, fetch_ready, exp_ok;

	// data at a word is its own low address bits, then their inverse
	function automatic mem_word_t mem_word(input addr_t a);
		return {~a[31:0], a[31:0]};
	endfunction

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic flag_error(input string msg);
		errors++;
		$display("ERROR at time %0t: %s", $time, msg);
	endtask

	clock_gen #(.PERIOD(PERIOD), .RESET_CYCLES(RESET_CYCLES)) clock_gen_i (
		.clock (clock),
		.reset (reset)
	);

	fetch_stage #(.RESET_PC1(RESET_PC1), .RESET_PC2(RESET_PC2)) dut_i (
		.clock        (clock),
		.reset        (reset),
		.imem_data    (imem_data),
		.imem_valid   (imem_valid),
		.fetch_enable (fetch_enable),
		.two_threads  (two_threads),
		.stall        (stall),
		.redirect     (redirect),
		.fetch_addr   (fetch_addr),
		.packet       (packet)
	);

	assign imem_data = mem_word(fetch_addr);  // memory answers in the same cycle

	////////////////////////////////////////////////////////////
	// shadow model
	////////////////////////////////////////////////////////////

	assign exp_addr       = (exp_state == THREAD1_IS_EX) ? exp_pc1 : exp_pc2;
	assign exp_rob        = (exp_state == THREAD1_IS_EX) ? stall.rob[0] : stall.rob[1];
	assign redirect_self  = redirect.taken && (redirect.thread == exp_state);
	assign fetch_ready    = imem_valid && fetch_enable && !stall.rs && !stall.rat
		&& !stall.mem_hazard && !exp_rob;
	assign exp_ok         = fetch_ready && !redirect_self;  // wrong-path word is dropped
	assign exp_next_state = (two_threads && exp_state == THREAD1_IS_EX) ? THREAD2_IS_EX
		: THREAD1_IS_EX;

	always @(posedge clock)
	begin
		if (reset)
		begin
			exp_state <= THREAD1_IS_EX;
			exp_pc1   <= RESET_PC1;
			exp_pc2   <= RESET_PC2;
		end
		else
		begin
			exp_state <= exp_next_state;
			if (redirect.taken && redirect.thread == THREAD1_IS_EX)
				exp_pc1 <= redirect.target & ~64'h7;
			else if (exp_ok && exp_state == THREAD1_IS_EX)
				exp_pc1 <= exp_pc1 + 64'd8;
			if (redirect.taken && redirect.thread == THREAD2_IS_EX)
				exp_pc2 <= redirect.target & ~64'h7;
			else if (exp_ok && exp_state == THREAD2_IS_EX)
				exp_pc2 <= exp_pc2 + 64'd8;
			packets   <= packets + packet.valid;
			redirects <= redirects + redirect.taken;
		end
	end

	////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////

	reset_state_a: assert property (@(posedge clock)
		reset |=> !packet.valid && fetch_addr == RESET_PC1)
		else flag_error("state after reset wrong");

	// selector order and both pcs, seen through the address port
	fetch_addr_a: assert property (@(posedge clock) disable iff (reset)
		fetch_addr == exp_addr)
		else flag_error("fetch_addr differs from the shadow pc");

	packet_a: assert property (@(posedge clock) disable iff (reset)
		exp_ok |=> packet.valid && packet.pc == $past(exp_addr)
			&& packet.thread == $past(exp_state)
			&& {packet.inst2, packet.inst1} == mem_word($past(exp_addr)))
		else flag_error("fetch packet missing or wrong");

	no_packet_a: assert property (@(posedge clock) disable iff (reset)
		!exp_ok |=> !packet.valid)
		else flag_error("packet valid after a failed fetch");

	redirect_squash_a: assert property (@(posedge clock) disable iff (reset)
		redirect_self && fetch_ready |=> !packet.valid)
		else flag_error("redirect did not squash the packet");

	// new address shows up at once when the target thread is next
	redirect_addr_a: assert property (@(posedge clock) disable iff (reset)
		redirect.taken && redirect.thread == exp_next_state
			|=> fetch_addr == ($past(redirect.target) & ~64'h7))
		else flag_error("redirect target not on fetch_addr");

	stall_hold_a: assert property (@(posedge clock) disable iff (reset)
		!two_threads && exp_state == THREAD1_IS_EX && !exp_ok
			&& !(redirect.taken && redirect.thread == THREAD1_IS_EX)
			|=> fetch_addr == $past(fetch_addr))
		else flag_error("fetch address moved during a stall");

	single_thread_a: assert property (@(posedge clock) disable iff (reset)
		!two_threads |-> ##2 (!packet.valid || packet.thread == THREAD1_IS_EX))
		else flag_error("thread 2 packet in single-thread mode");

	////////////////////////////////////////////////////////////
	// stimulus, watchdog and report
	////////////////////////////////////////////////////////////

	initial
	begin
		logic [31:0] rnd;
		logic [31:0] rnd_target;
		rnd          = 32'hc022;
		imem_valid   = 1'b0;
		fetch_enable = 1'b0;
		two_threads  = 1'b1;
		stall        = '0;
		redirect     = '0;
		wait (!reset);
		for (int cycle = 0; cycle < NUM_CYCLES; cycle++)
		begin
			@(posedge clock);
			rnd        = xorshift(rnd);
			rnd_target = xorshift(rnd ^ 32'h5a5a_0f0f);
			imem_valid       <= (rnd[2:0] != 3'd0);    // missing about 1 in 8
			stall.rs         <= (rnd[5:3] == 3'd0);
			stall.rat        <= (rnd[8:6] == 3'd0);
			stall.mem_hazard <= (rnd[11:9] == 3'd0);
			stall.rob        <= {rnd[17:15] == 3'd0, rnd[14:12] == 3'd0};
			redirect.taken   <= (rnd[21:18] == 4'd0);  // about 1 in 16
			redirect.thread  <= rnd[22] ? THREAD2_IS_EX : THREAD1_IS_EX;
			redirect.target  <= {32'h0, rnd_target[31:3], 3'b000};
			fetch_enable     <= (rnd[27:23] != 5'd0);
			two_threads      <= !(cycle >= 400 && cycle < 600);  // single-thread phase
		end
		@(posedge clock);
		redirect.taken <= 1'b0;
		repeat (3) @(posedge clock);
		$display("run over: %0d errors, %0d packets, %0d redirects", errors, packets,
			redirects);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

	initial
	begin
		#(TIMEOUT);
		$display("watchdog: the run did not finish within %0d time units", TIMEOUT);
		$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

/* test/clock_gen.sv */
/*
 * testbench clock and synchronous reset
 */
`default_nettype none

module clock_gen #(
	parameter int PERIOD       = 20,
	parameter int RESET_CYCLES = 4
) (
	output logic clock,
	output logic reset
);

	initial
	begin
		clock = 1'b0;
		forever #(PERIOD / 2) clock = ~clock;
	end

	initial
	begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;  // released on an edge, like any other input
	end

endmodule

`default_nettype wire

/* verilog/fetch_stage.sv */
/*
 * two-thread fetch front end
 * one pc per thread, a selector, the imem address mux and the fetch packet register
 */
`default_nettype none

module fetch_stage #(
	parameter fetch_pkg::addr_t RESET_PC1 = 64'h0000,  // thread 1 start address
	parameter fetch_pkg::addr_t RESET_PC2 = 64'h1000   // thread 2 start address
) (
	input  logic                     clock,
	input  logic                     reset,
	input  fetch_pkg::mem_word_t     imem_data,     // word at fetch_addr, same cycle
	input  logic                     imem_valid,    // low while the word is not back
	input  logic                     fetch_enable,
	input  logic                     two_threads,
	input  fetch_pkg::stall_t        stall,
	input  fetch_pkg::redirect_t     redirect,
	output fetch_pkg::addr_t         fetch_addr,    // to instruction memory
	output fetch_pkg::fetch_packet_t packet         // registered, one cycle after address
);
	import fetch_pkg::*;

	thread_state_t state;
	logic          fetch_ok;              // shared part of the fetch condition
	logic          active1, active2;
	logic          redirect1, redirect2;  // redirect strobe per thread
	addr_t         pc1, pc2;
	logic          fetched1, fetched2;
	logic          fetched;               // active thread's fetch succeeded

	////////////////////////////////////////////////////////////
	// control decode
	////////////////////////////////////////////////////////////

	assign fetch_ok  = imem_valid && fetch_enable && !(stall.rs || stall.rat || stall.mem_hazard);
	assign active1   = (state == THREAD1_IS_EX);
	assign active2   = (state == THREAD2_IS_EX);
	assign redirect1 = redirect.taken && (redirect.thread == THREAD1_IS_EX);
	assign redirect2 = redirect.taken && (redirect.thread == THREAD2_IS_EX);

	thread_select thread_select_i (
		.clock       (clock),
		.reset       (reset),
		.two_threads (two_threads),
		.state       (state)
	);

	fetch_pc #(.RESET_PC(RESET_PC1)) fetch_pc1_i (
		.clock          (clock),
		.reset          (reset),
		.active         (active1),
		.fetch_ok       (fetch_ok),
		.rob_stall      (stall.rob[0]),
		.redirect_taken (redirect1),
		.target         (redirect.target),
		.pc             (pc1),
		.fetched        (fetched1)
	);

	fetch_pc #(.RESET_PC(RESET_PC2)) fetch_pc2_i (
		.clock          (clock),
		.reset          (reset),
		.active         (active2),
		.fetch_ok       (fetch_ok),
		.rob_stall      (stall.rob[1]),
		.redirect_taken (redirect2),
		.target         (redirect.target),
		.pc             (pc2),
		.fetched        (fetched2)
	);

	////////////////////////////////////////////////////////////
	// address mux and packet register
	////////////////////////////////////////////////////////////

	assign fetch_addr = active1 ? pc1 : pc2;
	assign fetched    = active1 ? fetched1 : fetched2;  // only the active one can be high

	always_ff @(posedge clock)
	begin
		packet.thread <= state;
		packet.pc     <= fetch_addr;
		packet.inst1  <= imem_data[31:0];   // lower half first in program order
		packet.inst2  <= imem_data[63:32];
		if (reset)
		begin
			packet.valid <= 1'b0;
		end
		else
		begin
			packet.valid <= fetched;
		end
	end

	// whichever pc the selector picks, memory only sees word addresses
	fetch_addr_aligned_a: assert property (
		@(posedge clock) disable iff (reset)
		fetch_addr[2:0] == 3'b000
	);

endmodule

`default_nettype wire

/* verilog/thread_select.sv */
/*
 * fetch thread selector
 * alternates threads in two-thread mode, parks on thread 1 otherwise
 */
`default_nettype none

module thread_select (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     two_threads,  // both threads running
	output fetch_pkg::thread_state_t state         // thread fetching this cycle
);
	import fetch_pkg::*;

	thread_state_t next_state;

	////////////////////////////////////////////////////////////
	// state transition
	////////////////////////////////////////////////////////////

	always_comb
	begin
		if (!two_threads)
		begin
			next_state = THREAD1_IS_EX;  // single thread, park
		end
		else
		begin
			// round robin, one cycle each
			case (state)
				THREAD1_IS_EX: next_state = THREAD2_IS_EX;
				THREAD2_IS_EX: next_state = THREAD1_IS_EX;
				default:       next_state = THREAD1_IS_EX;
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= THREAD1_IS_EX;
		end
		else
		begin
			state <= next_state;
		end
	end

	// thread 2 gets no slot once single-thread mode is seen
	single_thread_park_a: assert property (
		@(posedge clock) disable iff (reset)
		!two_threads |=> state == THREAD1_IS_EX
	);

endmodule

`default_nettype wire

/* verilog/fetch_pc.sv */
/*
 * per thread fetch program counter
 * picks redirect, advance by 8 or hold, in that priority
 */
`default_nettype none

module fetch_pc #(
	parameter fetch_pkg::addr_t RESET_PC = 64'h0  // must be 8-byte aligned
) (
	input  logic             clock,
	input  logic             reset,
	input  logic             active,          // this thread owns the fetch port
	input  logic             fetch_ok,        // memory word present, no shared stall
	input  logic             rob_stall,       // this thread's rob is full
	input  logic             redirect_taken,  // taken branch for this thread
	input  fetch_pkg::addr_t target,          // branch target
	output fetch_pkg::addr_t pc,              // current fetch address
	output logic             fetched          // this cycle's fetch goes down the pipe
);
	import fetch_pkg::*;

	addr_t target_aligned;  // target with the byte offset dropped
	addr_t next_pc;

	////////////////////////////////////////////////////////////
	// fetch success
	////////////////////////////////////////////////////////////

	// a redirect in the same cycle squashes the word just read,
	// it belongs to the wrong path
	assign fetched = active && fetch_ok && !rob_stall && !redirect_taken;

	// two instructions per word, so the word address drops three bits
	assign target_aligned = {target[63:3], 3'b000};

	////////////////////////////////////////////////////////////
	// next pc
	////////////////////////////////////////////////////////////

	always_comb
	begin
		if (redirect_taken)
		begin
			next_pc = target_aligned;  // overrides every stall, else the branch is lost
		end
		else if (fetched)
		begin
			next_pc = pc + 64'd8;  // sequential, next pair of instructions
		end
		else
		begin
			// stalled, idle or memory not ready
			// keep the address so the same word is tried again
			next_pc = pc;
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			pc <= RESET_PC;
		end
		else
		begin
			pc <= next_pc;
		end
	end

	////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////

	// the pc only ever takes aligned values, so the port never sees an offset
	pc_aligned_a: assert property (
		@(posedge clock) disable iff (reset)
		pc[2:0] == 3'b000
	);

	// redirect lands one cycle later no matter what the stalls or the selector do
	redirect_wins_a: assert property (
		@(posedge clock) disable iff (reset)
		redirect_taken |=> pc == $past(target_aligned)
	);

endmodule

`default_nettype wire

/* verilog/fetch_pkg.sv */
/*
 * fetch front end shared types
 * addresses, instruction words, thread state, stall, redirect and packet structs
 */
`default_nettype none

package fetch_pkg;

	////////////////////////////////////////////////////////////
	// plain vectors with a meaning
	////////////////////////////////////////////////////////////

	typedef logic [63:0] addr_t;      // instruction address, fetched 8-byte aligned
	typedef logic [31:0] inst_t;      // one instruction
	typedef logic [63:0] mem_word_t;  // imem word, low half is the first instruction

	// which hardware thread owns the fetch port this cycle
	typedef enum logic {
		THREAD1_IS_EX = 1'b0,
		THREAD2_IS_EX = 1'b1
	} thread_state_t;

	////////////////////////////////////////////////////////////
	// grouped signals
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic       rs;          // reservation stations full
		logic       rat;         // free list empty, rename cannot allocate
		logic       mem_hazard;  // data side holds the memory port
		logic [1:0] rob;         // per thread rob full, bit 0 is thread 1
	} stall_t;

	typedef struct packed {
		logic          taken;   // taken branch resolved this cycle
		thread_state_t thread;  // thread whose pc gets the target
		addr_t         target;  // branch target, low bits ignored
	} redirect_t;

	typedef struct packed {
		logic          valid;  // both instructions usable
		thread_state_t thread; // thread that fetched them
		addr_t         pc;     // aligned address of inst1
		inst_t         inst1;  // instruction at pc
		inst_t         inst2;  // instruction at pc + 4
	} fetch_packet_t;

endpackage

`default_nettype wire
